// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - rtl/fetch_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/slot_predecode.sv
  - rtl/fetch_queue.sv
  - rtl/fetch_top.sv
  - target: test
    files:
      - testbench/tb_fetch_top.sv

// File: project.f
rtl/fetch_pkg.sv
rtl/fetch_stage.sv
rtl/slot_predecode.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
testbench/tb_fetch_top.sv

// File: rtl/fetch_pkg.sv
// fetch front end shared types
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int num_super    = 2;                        // slots per fetch word
  localparam int queue_depth  = 8;                        // fetch queue entries
  localparam int credit_width = 4;                        // holds 0 .. queue_depth
  localparam int pc_width     = 32;
  localparam int inst_width   = 32;                       // one instruction slot
  localparam int word_width   = num_super * inst_width;   // one imem word
  localparam int imm_width    = 16;                       // branch offset in ir[15:0]
  localparam int ptr_width    = $clog2(queue_depth);      // queue read / write pointers

  //////////////////////////////////////////////////////////////////////
  // opcodes, taken from ir[31:28]
  //////////////////////////////////////////////////////////////////////

  // unlisted codes fold into op_nop in the predecoder
  typedef enum logic [3:0] {
    op_alu    = 4'b0000,
    op_branch = 4'b0001,   // conditional, static backward-taken rule
    op_jump   = 4'b0010,   // unconditional, always predicted taken
    op_nop    = 4'b1111
  } opcode_t;

  //////////////////////////////////////////////////////////////////////
  // pipeline payloads
  //////////////////////////////////////////////////////////////////////

  // raw slot as cut out of the memory word
  typedef struct packed {
    logic                  valid;
    logic [pc_width-1:0]   pc;
    logic [inst_width-1:0] ir;
  } fetch_slot_t;

  // slot after predecode
  typedef struct packed {
    logic                  valid;
    logic [pc_width-1:0]   pc;
    logic [inst_width-1:0] ir;
    opcode_t               opcode;
    logic                  taken;    // static prediction
    logic [pc_width-1:0]   target;   // pc + 4 * imm
  } predecode_t;

  // what the consumer sees at the queue head
  typedef struct packed {
    logic [pc_width-1:0]   pc;
    logic [inst_width-1:0] ir;
    opcode_t               opcode;
    logic [pc_width-1:0]   next_pc;  // predicted successor
  } queue_entry_t;

  // pc change request back to the fetch stage
  typedef struct packed {
    logic                valid;
    logic [pc_width-1:0] pc;
  } redirect_t;

endpackage

// File: rtl/fetch_queue.sv
// fetch queue with redirect merge
`timescale 1ns/1ps

module fetch_queue (
  input  logic                                            clock,
  input  logic                                            reset,
  input  fetch_pkg::predecode_t [fetch_pkg::num_super-1:0] lanes,
  input  logic                                            flush_valid,
  input  logic [fetch_pkg::pc_width-1:0]                  flush_pc,
  input  logic                                            deq,
  output fetch_pkg::redirect_t                            redirect,
  output logic [fetch_pkg::credit_width-1:0]              credit_return,
  output logic                                            out_valid,
  output fetch_pkg::queue_entry_t                         out_entry
);

  import fetch_pkg::*;

  queue_entry_t            mem [queue_depth];            // circular buffer storage
  logic [ptr_width-1:0]    wr_ptr;
  logic [ptr_width-1:0]    rd_ptr;
  logic [credit_width-1:0] count;                        // occupancy from 0 to queue_depth

  logic [num_super-1:0]    keep;                         // lane is written
  logic [ptr_width-1:0]    wr_idx [num_super];           // compacted write slot per lane
  queue_entry_t            entry [num_super];
  logic [credit_width-1:0] write_count;
  logic [credit_width-1:0] kill_count;                   // valid lanes behind a taken one
  logic                    taken_any;
  logic [pc_width-1:0]     taken_target;
  logic                    deq_fire;

  //////////////////////////////////////////////////////////////////////
  // lane selection in program order
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    taken_any    = 1'b0;
    taken_target = '0;
    write_count  = '0;
    kill_count   = '0;
    for (int i = 0; i < num_super; i++)
    begin
      keep[i]   = lanes[i].valid && !taken_any;          // stop after the first taken
      wr_idx[i] = wr_ptr + write_count[ptr_width-1:0];   // packs around the skipped slot
      if (keep[i])
      begin
        write_count = write_count + credit_width'(1);
      end
      else if (lanes[i].valid)
      begin
        kill_count = kill_count + credit_width'(1);      // shadow of a taken slot
      end
      if (keep[i] && lanes[i].taken)
      begin
        taken_any    = 1'b1;
        taken_target = lanes[i].target;                  // lowest taken lane wins
      end
    end
  end

  // entry payload with next_pc from the prediction
  always_comb
  begin
    for (int i = 0; i < num_super; i++)
    begin
      entry[i].pc      = lanes[i].pc;
      entry[i].ir      = lanes[i].ir;
      entry[i].opcode  = lanes[i].opcode;
      entry[i].next_pc = lanes[i].taken ? lanes[i].target : lanes[i].pc + pc_width'(4);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // redirect merge
  //////////////////////////////////////////////////////////////////////

  // backend flush beats a predicted taken branch
  always_comb
  begin
    if (flush_valid)
    begin
      redirect.valid = 1'b1;
      redirect.pc    = flush_pc;
    end
    else
    begin
      redirect.valid = taken_any;
      redirect.pc    = taken_target;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // buffer and pointers
  //////////////////////////////////////////////////////////////////////

  assign out_valid = count != '0;
  assign out_entry = mem[rd_ptr];                        // oldest entry
  assign deq_fire  = deq && out_valid && !flush_valid;   // no pop while flushing

  always_ff @(posedge clock)
  begin
    if (!flush_valid)
    begin
      for (int i = 0; i < num_super; i++)
      begin
        if (keep[i])
        begin
          mem[wr_idx[i]] <= entry[i];
        end
      end
    end
  end

  // credit_return is the registered count the fetch stage adds next cycle
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= '0;
    end
    else if (flush_valid)
    begin
      wr_ptr        <= '0;                               // empty at the next edge
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= count + write_count + kill_count; // occupancy plus dropped lanes
    end
    else
    begin
      wr_ptr        <= wr_ptr + write_count[ptr_width-1:0];
      rd_ptr        <= rd_ptr + ptr_width'(deq_fire);
      count         <= count + write_count - credit_width'(deq_fire);
      credit_return <= credit_width'(deq_fire) + kill_count;
    end
  end

endmodule

// File: rtl/fetch_stage.sv
// fetch stage with credit counter
`timescale 1ns/1ps

module fetch_stage (
  input  logic                                             clock,
  input  logic                                             reset,
  input  logic [fetch_pkg::word_width-1:0]                 imem_data,
  input  logic                                             imem_valid,
  input  fetch_pkg::redirect_t                             redirect,
  input  logic [fetch_pkg::credit_width-1:0]               credit_return,
  output logic [fetch_pkg::pc_width-1:0]                   imem_addr,
  output fetch_pkg::fetch_slot_t [fetch_pkg::num_super-1:0] slots
);

  import fetch_pkg::*;

  logic [pc_width-1:0]     pc_reg;     // pc being fetched this cycle
  logic [pc_width-1:0]     word_pc;    // pc with the slot offset dropped
  logic [credit_width-1:0] credits;    // free queue entries seen from here
  logic [credit_width-1:0] fetched;    // slots handed to the queue this cycle
  logic                    can_fetch;
  logic                    accept;

  //////////////////////////////////////////////////////////////////////
  // address and slot split
  //////////////////////////////////////////////////////////////////////

  assign word_pc   = {pc_reg[pc_width-1:3], 3'b000};
  assign imem_addr = word_pc;                                  // 8-byte aligned word

  // need room for a full word, whatever the start slot
  assign can_fetch = credits >= credit_width'(num_super);
  assign accept    = imem_valid && can_fetch;

  always_comb
  begin
    fetched = '0;
    for (int i = 0; i < num_super; i++)
    begin
      // a start at pc[2] skips slot 0
      slots[i].valid = accept && (i >= int'(pc_reg[2]));
      slots[i].pc    = word_pc + pc_width'(4 * i);
      slots[i].ir    = imem_data[i*inst_width +: inst_width];  // slot 0 in low half
      fetched        = fetched + credit_width'(slots[i].valid);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pc register
  //////////////////////////////////////////////////////////////////////

  // a redirect wins over a stall, otherwise it would be lost
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc_reg <= '0;
    end
    else if (redirect.valid)
    begin
      pc_reg <= redirect.pc;                                   // flush or predicted taken
    end
    else if (accept)
    begin
      pc_reg <= word_pc + pc_width'(num_super * 4);            // next aligned word
    end
  end

  //////////////////////////////////////////////////////////////////////
  // credit counter
  //////////////////////////////////////////////////////////////////////

  // spend on fetch, refill from the queue's registered count
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      credits <= credit_width'(queue_depth);                   // queue starts empty
    end
    else
    begin
      credits <= credits - fetched + credit_return;
    end
  end

endmodule

// File: rtl/fetch_top.sv
// superscalar fetch front end
`timescale 1ns/1ps

module fetch_top (
  input  logic                             clock,
  input  logic                             reset,
  output logic [fetch_pkg::pc_width-1:0]   imem_addr,
  input  logic [fetch_pkg::word_width-1:0] imem_data,
  input  logic                             imem_valid,
  input  logic                             flush_valid,
  input  logic [fetch_pkg::pc_width-1:0]   flush_pc,
  input  logic                             deq,
  output logic                             out_valid,
  output fetch_pkg::queue_entry_t          out_entry
);

  import fetch_pkg::*;

  fetch_slot_t [num_super-1:0] slots;          // raw slots from the fetch word
  predecode_t  [num_super-1:0] lanes;          // classified slots into the queue
  redirect_t                   redirect;       // merged flush / taken redirect
  logic [credit_width-1:0]     credit_return;  // freed entries, registered in the queue

  //////////////////////////////////////////////////////////////////////
  // pc, memory word split and credits
  //////////////////////////////////////////////////////////////////////

  fetch_stage fetch_stage_inst (
    .clock         (clock),
    .reset         (reset),
    .imem_data     (imem_data),
    .imem_valid    (imem_valid),
    .redirect      (redirect),
    .credit_return (credit_return),
    .imem_addr     (imem_addr),
    .slots         (slots)
  );

  //////////////////////////////////////////////////////////////////////
  // one predecoder per slot
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < num_super; i++)
  begin : gen_lane
    slot_predecode slot_predecode_inst (
      .slot_in  (slots[i]),
      .slot_out (lanes[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // in-order queue toward the consumer
  //////////////////////////////////////////////////////////////////////

  fetch_queue fetch_queue_inst (
    .clock         (clock),
    .reset         (reset),
    .lanes         (lanes),
    .flush_valid   (flush_valid),
    .flush_pc      (flush_pc),
    .deq           (deq),
    .redirect      (redirect),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_entry     (out_entry)
  );

endmodule

// File: rtl/slot_predecode.sv
// slot predecode and static prediction
`timescale 1ns/1ps

module slot_predecode (
  input  fetch_pkg::fetch_slot_t slot_in,
  output fetch_pkg::predecode_t  slot_out
);

  import fetch_pkg::*;

  opcode_t               opcode;
  logic [imm_width-1:0]  imm;        // signed word offset
  logic [pc_width-1:0]   offset;     // byte offset, sign extended
  logic                  backward;
  logic                  taken;

  //////////////////////////////////////////////////////////////////////
  // opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (slot_in.ir[31:28])
      op_alu:    opcode = op_alu;
      op_branch: opcode = op_branch;
      op_jump:   opcode = op_jump;
      default:   opcode = op_nop;           // unused codes behave as nop
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // target and prediction
  //////////////////////////////////////////////////////////////////////

  assign imm      = slot_in.ir[imm_width-1:0];
  assign backward = imm[imm_width-1];                                  // negative offset
  assign offset   = {{(pc_width-imm_width-2){imm[imm_width-1]}}, imm, 2'b00};

  // jumps always, branches only when looping back
  always_comb
  begin
    case (opcode)
      op_jump:   taken = slot_in.valid;
      op_branch: taken = slot_in.valid && backward;
      default:   taken = 1'b0;
    endcase
  end

  assign slot_out.valid  = slot_in.valid;
  assign slot_out.pc     = slot_in.pc;
  assign slot_out.ir     = slot_in.ir;
  assign slot_out.opcode = opcode;
  assign slot_out.taken  = taken;
  assign slot_out.target = slot_in.pc + offset;   // pc relative

endmodule

// File: testbench/tb_fetch_top.sv
// fetch front end testbench
`timescale 1ns/1ps

module tb_fetch_top;

  import fetch_pkg::*;

  typedef struct packed {
    logic [pc_width-1:0]   pc;
    logic [inst_width-1:0] ir;
    logic [3:0]            opcode;
    logic [pc_width-1:0]   next_pc;
  } expect_t;

  localparam int len_seq      = 200;
  localparam int len_branch   = 400;
  localparam int len_hold     = 30;                // deq held low
  localparam int len_drain    = queue_depth + 4;
  localparam int len_resume   = 100;
  localparam int len_stall    = 400;
  localparam int len_flush    = 500;
  localparam int total_cycles = 2 * 4 + len_seq + len_branch + len_hold + len_drain
                                + len_resume + len_stall + len_flush;

  logic                  clock;
  logic                  reset;
  logic [pc_width-1:0]   imem_addr;
  logic [word_width-1:0] imem_data;
  logic                  imem_valid;
  logic                  flush_valid;
  logic [pc_width-1:0]   flush_pc;
  logic                  deq;
  logic                  out_valid;
  queue_entry_t          out_entry;

  logic [word_width-1:0] image [256];      // 2 KiB image repeating over the address space
  logic [31:0]           lfsr_state;
  string                 test_name;
  int                    valid_mode;       // 0 always, 1 random, 2 never
  int                    deq_mode;         // 0 never, 1 always, 2 random
  bit                    flush_mode;
  int                    pop_total;
  int                    cycle_count;
  int                    drain_start;
  logic [pc_width-1:0]   ref_pc;           // next pc on the predicted path
  logic [pc_width-1:0]   flush_target;
  logic                  flush_pending;    // next pop must start at flush_target
  expect_t               expected;

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;             // 10 ns period
  end

  fetch_top fetch_top_inst (
    .clock       (clock),
    .reset       (reset),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .imem_valid  (imem_valid),
    .flush_valid (flush_valid),
    .flush_pc    (flush_pc),
    .deq         (deq),
    .out_valid   (out_valid),
    .out_entry   (out_entry)
  );

  assign imem_data = image[imem_addr[10:3]];   // zero wait memory

  //////////////////////////////////////////////////////////////////////
  // random source and memory image
  //////////////////////////////////////////////////////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value[i]   = lfsr_state[0];          // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  function automatic logic [inst_width-1:0] make_instruction(input bit with_control);
    logic [3:0]  pick;
    logic [3:0]  code;
    logic [15:0] imm;
    logic [11:0] middle;
    pick = 4'(take_bits(4));
    if (with_control && pick < 2)
      code = op_branch;                    // about one in eight
    else if (with_control && pick == 2)
      code = op_jump;
    else if (pick < 8)
      code = op_alu;
    else
      code = pick;                         // undefined codes decode as nop
    middle = 12'(take_bits(12));
    imm    = 16'(take_bits(16));
    if (code == op_branch || code == op_jump)
      imm = {{11{imm[4]}}, imm[4:0]};      // short reach of -16 .. 15 words
    return {code, middle, imm};
  endfunction

  task automatic fill_image(input bit with_control);
    for (int i = 0; i < 256; i++)
    begin
      image[i][31:0]  = make_instruction(with_control);
      image[i][63:32] = make_instruction(with_control);
    end
  endtask

  // expected entry at pc on the predicted path
  function automatic expect_t predict_step(input logic [pc_width-1:0] pc);
    expect_t               result;
    logic [word_width-1:0] word;
    logic [inst_width-1:0] ir;
    logic [pc_width-1:0]   target;
    int                    offset_words;   // signed word offset from ir[15:0]
    logic                  taken;
    word         = image[pc[10:3]];
    ir           = pc[2] ? word[63:32] : word[31:0];
    offset_words = int'($signed(ir[15:0]));
    target       = pc + 32'(offset_words * 4);
    taken        = (ir[31:28] == op_jump) || (ir[31:28] == op_branch && offset_words < 0);
    result.pc    = pc;
    result.ir    = ir;
    if (ir[31:28] == op_alu || ir[31:28] == op_branch || ir[31:28] == op_jump)
      result.opcode = ir[31:28];
    else
      result.opcode = op_nop;              // every other code reads as nop
    result.next_pc = taken ? target : pc + 32'd4;
    return result;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // error handling
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("MISMATCH test=%s check=%s expected=%h actual=%h",
               test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus, all on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    logic [31:0] pick;
    @(negedge clock);
    imem_valid  = (valid_mode == 0) || (valid_mode == 1 && take_bits(1) != 0);
    deq         = (deq_mode == 1) || (deq_mode == 2 && take_bits(2) != 0);
    flush_valid = 1'b0;
    if (flush_mode && take_bits(4) == 0)
    begin
      pick        = take_bits(9);
      flush_valid = 1'b1;
      flush_pc    = {21'b0, pick[8:0], 2'b00};   // may start mid word
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) drive_cycle();
  endtask

  // image changes only while the queue is held in reset
  task automatic apply_reset(input bit with_control);
    @(negedge clock);
    reset       = 1'b1;
    imem_valid  = 1'b0;
    deq         = 1'b0;
    flush_valid = 1'b0;
    fill_image(with_control);
    repeat (3)
    begin
      @(negedge clock);
      assert (out_valid === 1'b0 && imem_addr === '0)
      else
      begin
        $display("reset state wrong, out_valid %b imem_addr %h", out_valid, imem_addr);
        stop_on_failure();
      end
    end
    reset = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin
    if (reset)
    begin
      ref_pc        = '0;                  // walker restarts at pc 0
      flush_pending = 1'b0;
    end
    else if (flush_valid)
    begin
      ref_pc        = flush_pc;            // pops are ignored while flushing
      flush_target  = flush_pc;
      flush_pending = 1'b1;
    end
    else if (deq && out_valid)
    begin
      expected = predict_step(ref_pc);
      if (flush_pending)
        check_equal("pc after flush", flush_target, out_entry.pc);
      check_equal("pc", expected.pc, out_entry.pc);
      check_equal("ir", expected.ir, out_entry.ir);
      check_equal("opcode", 32'(expected.opcode), 32'(out_entry.opcode));
      check_equal("next_pc", expected.next_pc, out_entry.next_pc);
      ref_pc        = expected.next_pc;
      flush_pending = 1'b0;
      pop_total++;
    end
  end

  always @(posedge clock)
  begin
    cycle_count++;
    if (cycle_count > 4 * total_cycles)
    begin
      $display("timeout, the run did not finish within %0d cycles", 4 * total_cycles);
      stop_on_failure();
    end
  end

  initial
  begin
    lfsr_state  = 32'h922f_3980;
    reset       = 1'b1;
    imem_valid  = 1'b0;
    flush_valid = 1'b0;
    flush_pc    = '0;
    deq         = 1'b0;
    valid_mode  = 0;
    deq_mode    = 1;
    flush_mode  = 1'b0;
    test_name   = "sequential";
    apply_reset(1'b0);                     // alu and nop only
    run_cycles(len_seq);
    test_name = "predicted";
    apply_reset(1'b1);
    run_cycles(len_branch);
    test_name = "backpressure";
    deq_mode  = 0;
    run_cycles(len_hold - 20);
    repeat (20)
    begin
      drive_cycle();
      assert (out_valid === 1'b1)
      else
      begin
        $display("out_valid dropped while the queue was held full");
        stop_on_failure();
      end
    end
    drain_start = pop_total;
    valid_mode  = 2;                       // drain with no new fetches
    deq_mode    = 1;
    run_cycles(len_drain);
    assert (pop_total - drain_start <= queue_depth && out_valid === 1'b0)
    else
    begin
      $display("held queue gave %0d entries, out_valid %b", pop_total - drain_start, out_valid);
      stop_on_failure();
    end
    valid_mode = 0;
    run_cycles(len_resume);
    test_name  = "stalls";
    valid_mode = 1;
    deq_mode   = 2;
    run_cycles(len_stall);
    test_name  = "flush";
    flush_mode = 1'b1;
    run_cycles(len_flush);
    assert (pop_total > len_seq)
    else
    begin
      $display("too few entries were popped, only %0d", pop_total);
      stop_on_failure();
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule
